//--- sim.f
+incdir+verilog
verilog/steer_pkg.sv
verilog/steer_fltr.sv
verilog/result_writer.sv
verilog/host_reader.sv
verilog/result_bank.sv
verilog/steer_top.sv
tests/steer_sva.sv
tests/steer_tb.sv

//--- tests/steer_tb.sv
`timescale 1ns/1ps
`include "steer_settings.svh"

module steer_tb;

   logic                     clk;
   logic                     rst_n;
   logic                     new_data;
   steer_pkg::basis_t        basis;
   logic                     rd_strobe;
   logic [`STEER_ADDR_W-1:0] rd_addr;
   logic                     rd_busy;
   logic                     rd_valid;
   steer_pkg::resp_t         rd_data;
   logic [15:0]              wr_count;

   steer_pkg::resp_t exp_mem [`STEER_DEPTH];
   int               exp_count;
   int               mismatch_cnt;
   int               timeout_cnt;
   int               valid_cnt;
   steer_pkg::resp_t last_data;
   logic [31:0]      lcg_state;

   steer_top i_dut
   (
      .clk       (clk),
      .rst_n     (rst_n),
      .new_data  (new_data),
      .basis     (basis),
      .rd_strobe (rd_strobe),
      .rd_addr   (rd_addr),
      .rd_busy   (rd_busy),
      .rd_valid  (rd_valid),
      .rd_data   (rd_data),
      .wr_count  (wr_count)
   );

   always #20 clk = ~clk;

   // Returned words are picked up mid-cycle, where they are stable.
   always @(negedge clk)
   begin
      if (rd_valid)
      begin
         valid_cnt = valid_cnt + 1;
         last_data = rd_data;
      end
   end

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic steer_pkg::basis_t random_basis();
      steer_pkg::basis_t b;
      b.f1 = lcg_next() >> 4;
      b.f2 = lcg_next() >> 4;
      b.f3 = lcg_next() >> 4;
      b.h1 = lcg_next() >> 4;
      b.h2 = lcg_next() >> 4;
      b.h3 = lcg_next() >> 4;
      b.h4 = lcg_next() >> 4;
      return b;
   endfunction

   // Shift-and-add steering done in wide integers, then the top bits of each sum.
   function automatic steer_pkg::resp_t steer_model(steer_pkg::basis_t b);
      steer_pkg::resp_t r;
      longint f1;
      longint f2;
      longint f3;
      longint h1;
      longint h2;
      longint h3;
      longint h4;
      f1 = longint'(b.f1) >>> 1;
      f2 = longint'(b.f2) >>> 1;
      f3 = longint'(b.f3);
      h1 = (longint'(b.h1) >>> 2) + (longint'(b.h1) >>> 3);
      h2 = (longint'(b.h2) >>> 2) + (longint'(b.h2) >>> 3);
      h3 = longint'(b.h3) + (longint'(b.h3) >>> 4);
      h4 = longint'(b.h4) + (longint'(b.h4) >>> 4);
      r.re_z = 16'(longint'(b.f1) >>> 15);
      r.im_z = 16'(longint'(b.h1) >>> 15);
      r.re_p = 16'((f1 - f3 + f2) >>> 15);
      r.re_n = 16'((f1 + f3 + f2) >>> 15);
      r.im_p = 16'((h1 - h4 + h3 - h2) >>> 15);
      r.im_n = 16'((h1 + h4 + h3 + h2) >>> 15);
      return r;
   endfunction

   task automatic check_resp(string name, steer_pkg::resp_t exp, steer_pkg::resp_t act);
      if (exp !== act)
      begin
         mismatch_cnt++;
         $display("MISMATCH %s: expected %h actual %h", name, exp, act);
      end
   endtask

   task automatic check_count(string name, logic [15:0] exp, logic [15:0] act);
      if (exp !== act)
      begin
         mismatch_cnt++;
         $display("MISMATCH %s: expected wr_count %0d actual %0d", name, exp, act);
      end
   endtask

   task automatic apply_reset();
      @(posedge clk);
      rst_n <= 1'b0;
      repeat (3) @(posedge clk);
      rst_n    <= 1'b1;
      exp_count = 0;
   endtask

   // One strobe per call; the model result goes to the expected store in write order.
   task automatic send_basis(steer_pkg::basis_t b);
      @(posedge clk);
      new_data <= 1'b1;
      basis    <= b;
      exp_mem[exp_count % `STEER_DEPTH] = steer_model(b);
      exp_count++;
   endtask

   task automatic stop_data();
      @(posedge clk);
      new_data <= 1'b0;
   endtask

   task automatic wait_count(string name, int exp);
      int n;
      n = 0;
      @(negedge clk);
      while (wr_count != 16'(exp) && n < 100)
      begin
         @(negedge clk);
         n++;
      end
      if (n >= 100)
      begin
         timeout_cnt++;
         $display("%s: wr_count did not reach %0d in time", name, exp);
      end
      check_count(name, 16'(exp), wr_count);
   endtask

   task automatic wait_valid(string name, int start);
      int n;
      n = 0;
      while (valid_cnt == start && n < 100)
      begin
         @(negedge clk);
         n++;
      end
      if (n >= 100)
      begin
         timeout_cnt++;
         $display("%s: no read data returned in time", name);
      end
   endtask

   task automatic wait_idle(string name);
      int n;
      n = 0;
      @(negedge clk);
      while (rd_busy && n < 100)
      begin
         @(negedge clk);
         n++;
      end
      if (n >= 100)
      begin
         timeout_cnt++;
         $display("%s: reader stayed busy", name);
      end
   endtask

   task automatic read_slot(string name, int slot);
      int start;
      start = valid_cnt;
      @(posedge clk);
      rd_strobe <= 1'b1;
      rd_addr   <= `STEER_ADDR_W'(slot);
      @(posedge clk);
      rd_strobe <= 1'b0;
      wait_valid(name, start);
      check_resp(name, exp_mem[slot], last_data);
      wait_idle(name);
   endtask

   task automatic test_reset_state();
      new_data <= 1'b1; // A strobe held through reset must not write.
      apply_reset();
      new_data <= 1'b0;
      repeat (6) @(negedge clk);
      check_count("reset", 16'd0, wr_count);
      if (rd_valid !== 1'b0 || rd_busy !== 1'b0)
      begin
         timeout_cnt++;
         $display("reset: reader is not idle after reset");
      end
   endtask

   task automatic test_single();
      steer_pkg::basis_t b;
      b = '0;
      b.f1 = 28'sd40_000_000;
      send_basis(b);
      b = '0;
      b.h3 = 28'sd50_000_000;
      send_basis(b);
      b = '0;
      b.h4 = -28'sd30_000_000;
      send_basis(b);
      b = {7{28'h800_0000}};
      send_basis(b);
      stop_data();
      wait_count("single", 4);
      for (int i = 0; i < 4; i++)
         read_slot($sformatf("single[%0d]", i), i);
   endtask

   task automatic test_burst();
      apply_reset();
      for (int i = 0; i < 8; i++)
         send_basis(random_basis());
      stop_data();
      wait_count("burst", 8);
      for (int i = 0; i < 8; i++)
         read_slot($sformatf("burst[%0d]", i), i);
   endtask

   task automatic test_read_during_writes();
      int start;
      steer_pkg::resp_t old_word;
      old_word = exp_mem[2];
      start    = valid_cnt;
      for (int i = 0; i < 8; i++)
      begin
         send_basis(random_basis());
         rd_strobe <= (i == 3 || i == 5);
         rd_addr   <= (i == 3) ? 6'd2 : 6'd5; // The second strobe arrives while busy.
      end
      @(posedge clk);
      new_data  <= 1'b0;
      rd_strobe <= 1'b0;
      wait_valid("rd_during_wr", start);
      check_resp("rd_during_wr", old_word, last_data);
      wait_idle("rd_during_wr");
      repeat (10) @(negedge clk);
      if (valid_cnt != start + 1)
      begin
         timeout_cnt++;
         $display("rd_during_wr: strobe during busy was not ignored");
      end
      wait_count("rd_during_wr", 16);
   endtask

   task automatic test_wrap();
      apply_reset();
      for (int i = 0; i < 70; i++)
         send_basis(random_basis());
      stop_data();
      wait_count("wrap", 70);
      read_slot("wrap", 3);
   endtask

   initial
   begin
      clk          = 1'b0;
      rst_n        = 1'b0;
      new_data     = 1'b0;
      basis        = '0;
      rd_strobe    = 1'b0;
      rd_addr      = '0;
      exp_count    = 0;
      mismatch_cnt = 0;
      timeout_cnt  = 0;
      valid_cnt    = 0;
      last_data    = '0;
      lcg_state    = 32'h9fce_14a4;

      test_reset_state();
      test_single();
      test_burst();
      test_read_during_writes();
      test_wrap();

      $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, timeout_cnt);
      if (mismatch_cnt == 0 && timeout_cnt == 0)
         $display("Test OK");
      else
         $display("Test FAILED");
      $finish;
   end

endmodule

//--- tests/steer_sva.sv
`timescale 1ns/1ps

module steer_sva
(
   input logic clk,
   input logic rst_n,
   input logic wr_en,
   input logic rd_en,
   input logic rd_grant,
   input logic rd_valid,
   input logic rd_busy
);

   // A read that loses the bank to a write stays pending.
   assert property (@(posedge clk) disable iff (!rst_n) (rd_en && wr_en) |=> rd_en)
      else $error("pending read dropped while a write held the bank");

   assert property (@(posedge clk) disable iff (!rst_n) rd_grant |=> !rd_en)
      else $error("read still pending after its grant");

   assert property (@(posedge clk) disable iff (!rst_n) rd_valid |=> !rd_valid)
      else $error("rd_valid longer than one cycle");

   assert property (@(posedge clk) disable iff (!rst_n) rd_valid |-> rd_busy)
      else $error("rd_valid outside a busy read");

   // Busy may only drop once the word has been returned.
   assert property (@(posedge clk) disable iff (!rst_n) (rd_busy && !rd_valid) |=> rd_busy)
      else $error("rd_busy fell before rd_valid");

endmodule

bind steer_top steer_sva i_sva
(
   .clk      (clk),
   .rst_n    (rst_n),
   .wr_en    (wr.en),
   .rd_en    (rd.en),
   .rd_grant (rd_grant),
   .rd_valid (rd_valid),
   .rd_busy  (rd_busy)
);

//--- verilog/steer_top.sv
`timescale 1ns/1ps
`include "steer_settings.svh"

module steer_top
(
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     new_data,
   input  steer_pkg::basis_t        basis,
   input  logic                     rd_strobe,
   input  logic [`STEER_ADDR_W-1:0] rd_addr,
   output logic                     rd_busy,
   output logic                     rd_valid,
   output steer_pkg::resp_t         rd_data,
   output logic [15:0]              wr_count
);

   steer_pkg::resp_t    resp;
   steer_pkg::bank_wr_t wr;
   steer_pkg::bank_rd_t rd;
   logic                rd_grant;
   steer_pkg::resp_t    rd_word;

   steer_fltr i_fltr
   (
      .clk      (clk),
      .new_data (new_data),
      .basis    (basis),
      .resp     (resp)
   );

   result_writer i_writer
   (
      .clk      (clk),
      .rst_n    (rst_n),
      .new_data (new_data),
      .resp     (resp),
      .wr       (wr),
      .wr_count (wr_count)
   );

   host_reader i_reader
   (
      .clk       (clk),
      .rst_n     (rst_n),
      .rd_strobe (rd_strobe),
      .rd_addr   (rd_addr),
      .rd_grant  (rd_grant),
      .rd_word   (rd_word),
      .rd        (rd),
      .rd_busy   (rd_busy),
      .rd_valid  (rd_valid),
      .rd_data   (rd_data)
   );

   result_bank i_bank
   (
      .clk      (clk),
      .wr       (wr),
      .rd       (rd),
      .rd_grant (rd_grant),
      .rd_word  (rd_word)
   );

endmodule

//--- verilog/result_bank.sv
`timescale 1ns/1ps
`include "steer_settings.svh"

module result_bank
(
   input  logic                clk,
   input  steer_pkg::bank_wr_t wr,
   input  steer_pkg::bank_rd_t rd,
   output logic                rd_grant,
   output steer_pkg::resp_t    rd_word
);

   steer_pkg::resp_t mem [`STEER_DEPTH];

   // The filter path cannot stall, so a write always wins the bank.
   assign rd_grant = rd.en && !wr.en;

   always_ff @(posedge clk)
   begin
      if (wr.en)
         mem[wr.addr] <= wr.data;
   end

   always_ff @(posedge clk)
   begin
      if (rd_grant)
         rd_word <= mem[rd.addr]; // Held until the next granted read.
   end

endmodule

//--- verilog/host_reader.sv
`timescale 1ns/1ps
`include "steer_settings.svh"

module host_reader
(
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     rd_strobe,
   input  logic [`STEER_ADDR_W-1:0] rd_addr,
   input  logic                     rd_grant,
   input  steer_pkg::resp_t         rd_word,
   output steer_pkg::bank_rd_t      rd,
   output logic                     rd_busy,
   output logic                     rd_valid,
   output steer_pkg::resp_t         rd_data
);

   logic                     pending;
   logic [`STEER_ADDR_W-1:0] addr_q;

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         pending  <= 1'b0;
         rd_busy  <= 1'b0;
         rd_valid <= 1'b0;
      end
      else
      begin
         rd_valid <= rd_grant;
         if (rd_strobe && !rd_busy)
         begin
            pending <= 1'b1;
            rd_busy <= 1'b1;
         end
         else
         begin
            if (rd_grant)
               pending <= 1'b0;
            if (rd_valid)
               rd_busy <= 1'b0; // Busy covers the return cycle too.
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (rd_strobe && !rd_busy)
         addr_q <= rd_addr;
   end

   assign rd.en   = pending;
   assign rd.addr = addr_q;
   assign rd_data = rd_word;

endmodule

//--- verilog/result_writer.sv
`timescale 1ns/1ps
`include "steer_settings.svh"

module result_writer
(
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  new_data,
   input  steer_pkg::resp_t      resp,
   output steer_pkg::bank_wr_t   wr,
   output logic [15:0]           wr_count
);

   logic [2:0]               strobe_dly; // Follows the three filter stages.
   logic                     wr_en;
   logic [`STEER_ADDR_W-1:0] wr_addr;

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         strobe_dly <= '0;
         wr_en      <= 1'b0;
         wr_addr    <= '0;
         wr_count   <= '0;
      end
      else
      begin
         strobe_dly <= {strobe_dly[1:0], new_data};
         wr_en      <= strobe_dly[2]; // The filter output is fresh from here on.
         if (wr_en)
         begin
            wr_count <= wr_count + 16'd1;
            if (wr_addr == `STEER_ADDR_W'(`STEER_DEPTH - 1))
               wr_addr <= '0;
            else
               wr_addr <= wr_addr + 1'b1;
         end
      end
   end

   assign wr.en   = wr_en;
   assign wr.addr = wr_addr;
   assign wr.data = resp;   // The filter holds its output until the next strobe arrives.

endmodule

//--- verilog/steer_fltr.sv
`timescale 1ns/1ps

module steer_fltr
(
   input  logic              clk,
   input  logic              new_data,
   input  steer_pkg::basis_t basis,
   output steer_pkg::resp_t  resp
);

   steer_pkg::basis_t basis_q;

   // Stage 1 weighted terms, one bit wider than the basis.
   logic signed [28:0] re_z_t;
   logic signed [28:0] im_z_t;
   logic signed [28:0] f1_t;
   logic signed [28:0] f2_t;
   logic signed [28:0] f3_t;
   logic signed [28:0] h1_t;
   logic signed [28:0] h2_t;
   logic signed [28:0] h3_t;
   logic signed [28:0] h4_t;

   // Stage 2 sums.
   logic signed [30:0] re_z_s;
   logic signed [30:0] im_z_s;
   logic signed [30:0] re_p_s;
   logic signed [30:0] im_p_s;
   logic signed [30:0] re_n_s;
   logic signed [30:0] im_n_s;

   always_ff @(posedge clk)
   begin
      if (new_data)
         basis_q <= basis;
   end

   always_ff @(posedge clk)
   begin
      re_z_t <= basis_q.f1;
      im_z_t <= basis_q.h1;
      f1_t   <= basis_q.f1 >>> 1;
      f2_t   <= basis_q.f2 >>> 1;
      f3_t   <= basis_q.f3;
      h1_t   <= (basis_q.h1 >>> 2) + (basis_q.h1 >>> 3); // About 3/8.
      h2_t   <= (basis_q.h2 >>> 2) + (basis_q.h2 >>> 3);
      h3_t   <= basis_q.h3 + (basis_q.h3 >>> 4);         // About 17/16.
      h4_t   <= basis_q.h4 + (basis_q.h4 >>> 4);
   end

   always_ff @(posedge clk)
   begin
      re_z_s <= re_z_t;
      im_z_s <= im_z_t;
      re_p_s <= f1_t - f3_t + f2_t;
      re_n_s <= f1_t + f3_t + f2_t;
      im_p_s <= h1_t - h4_t + h3_t - h2_t; // The odd terms flip sign between orientations.
      im_n_s <= h1_t + h4_t + h3_t + h2_t;
   end

   // Keep the top 16 bits of each sum.
   always_ff @(posedge clk)
   begin
      resp.re_z <= re_z_s[30:15];
      resp.im_z <= im_z_s[30:15];
      resp.re_p <= re_p_s[30:15];
      resp.im_p <= im_p_s[30:15];
      resp.re_n <= re_n_s[30:15];
      resp.im_n <= im_n_s[30:15];
   end

endmodule

//--- verilog/steer_pkg.sv
`include "steer_settings.svh"

package steer_pkg;

   // Seven basis filter responses from the front end.
   typedef struct packed
   {
      logic signed [27:0] f1;
      logic signed [27:0] f2;
      logic signed [27:0] f3;
      logic signed [27:0] h1;
      logic signed [27:0] h2;
      logic signed [27:0] h3;
      logic signed [27:0] h4;
   } basis_t;

   // Complex responses at the zero, positive and negative orientations.
   typedef struct packed
   {
      logic signed [15:0] re_z;
      logic signed [15:0] im_z;
      logic signed [15:0] re_p;
      logic signed [15:0] im_p;
      logic signed [15:0] re_n;
      logic signed [15:0] im_n;
   } resp_t;

   typedef struct packed
   {
      logic                     en;
      logic [`STEER_ADDR_W-1:0] addr;
      resp_t                    data;
   } bank_wr_t;

   typedef struct packed
   {
      logic                     en;
      logic [`STEER_ADDR_W-1:0] addr;
   } bank_rd_t;

endpackage

//--- verilog/steer_settings.svh
`ifndef STEER_SETTINGS_SVH
`define STEER_SETTINGS_SVH

// The result bank size. The address width must cover the depth.
`define STEER_ADDR_W 6
`define STEER_DEPTH 64

`endif
